// File: compile.f
+incdir+include
hw/ldiPkg.sv
hw/fetchUnit.sv
hw/controlSequencer.sv
hw/registerFile.sv
hw/busDatapath.sv
hw/ldiCore.sv
test/clockGen.sv
test/ldiCoreTb.sv

// File: hw/busDatapath.sv
`timescale 1ns/1ps
`include "ldi_config.svh"

module busDatapath import ldiPkg::*; (
	input logic clk,
	input logic reset,
	input logic yLoad,
	input logic zLoad,
	input logic zIncMode,
	input busSrc_t busSrc,
	input word_t pc,
	input word_t baseOut,
	input word_t instr,
	output word_t bus
);

	word_t yReg;
	word_t zReg;  // Z low only, no high half here
	word_t cExt;
	word_t zNext;

	// C field, sign extended to a full word
	assign cExt = {{(`DATA_WIDTH - `CONST_WIDTH){instr[`CONST_WIDTH-1]}},
		instr[`CONST_WIDTH-1:0]};

	// single driver on the bus each step
	always_comb begin
		case (busSrc)
			PC: bus = pc;
			ZLOW: bus = zReg;
			REGB: bus = baseOut;
			CONST: bus = cExt;
			default: bus = '0;
		endcase
	end

	// adder, IncPC mode or Y + bus
	assign zNext = zIncMode ? bus + 1'b1 : yReg + bus;

	always_ff @(posedge clk) begin
		if (reset) begin
			yReg <= '0;
			zReg <= '0;
		end else begin
			if (yLoad)
				yReg <= bus;
			if (zLoad)
				zReg <= zNext; // carry out dropped, wraps
		end
	end

endmodule

// File: hw/controlSequencer.sv
`timescale 1ns/1ps
`include "ldi_config.svh"

module controlSequencer import ldiPkg::*; (
	input logic clk,
	input logic reset,
	input logic run,
	input word_t instr,
	input logic fetchDone,
	output logic fetchReq,
	output logic pcLoad,
	output logic yLoad,
	output logic zLoad,
	output logic zIncMode, // Z = bus + 1 instead of Y + bus
	output logic regWrite,
	output logic halted,
	output busSrc_t busSrc
);

	seqState_t state, nextState;
	opcode_t opcode;

	assign opcode = instr[31:27];

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= nextState;
	end

	// one line of enables per step
	always_comb begin
		nextState = state;
		fetchReq = 1'b0;
		pcLoad = 1'b0;
		yLoad = 1'b0;
		zLoad = 1'b0;
		zIncMode = 1'b0;
		regWrite = 1'b0;
		busSrc = NONE;
		case (state)
			IDLE: begin
				if (run)
					nextState = T0;
			end
			T0: begin
				busSrc = PC; // pc out, IncPC into Z
				zLoad = 1'b1;
				zIncMode = 1'b1;
				fetchReq = 1'b1; // held until the read completes
				if (fetchDone)
					nextState = T1;
			end
			T1: begin
				busSrc = ZLOW;
				pcLoad = 1'b1;
				nextState = T2;
			end
			T2: begin
				// only opcode test in the design
				if (opcode == `OP_LDI)
					nextState = T3;
				else if (opcode == `OP_HALT)
					nextState = HALTED;
				else
					nextState = T0; // anything else is a no-op
			end
			T3: begin
				busSrc = REGB; // Grb with BAout
				yLoad = 1'b1;
				nextState = T4;
			end
			T4: begin
				busSrc = CONST;
				zLoad = 1'b1; // Y + C
				nextState = T5;
			end
			T5: begin
				busSrc = ZLOW;
				regWrite = 1'b1; // Gra, Rin
				nextState = T0;
			end
			HALTED: nextState = HALTED; // only reset leaves
			default: nextState = IDLE;
		endcase
	end

	assign halted = (state == HALTED);

endmodule

// File: hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import ldiPkg::*; (
	input logic clk,
	input logic reset,
	input logic fetchReq,   // held high through T0
	input logic pcLoad,     // T1 step
	input word_t newPc,     // from the internal bus
	output logic wbCyc,
	output logic wbStb,
	output word_t wbAdr,    // word address
	input word_t wbDatIn,
	input logic wbAck,
	output logic fetchDone, // one cycle, same cycle as ack
	output word_t instr,    // instruction register
	output word_t pc
);

	logic cycleOpen; // a read is on the bus

	// classic cycle, cyc and stb move together
	assign wbCyc = cycleOpen;
	assign wbStb = cycleOpen;

	// ack only counts while our cycle is open
	assign fetchDone = cycleOpen & wbAck;

	always_ff @(posedge clk) begin
		if (reset) begin
			cycleOpen <= 1'b0;
		end else if (fetchDone) begin
			cycleOpen <= 1'b0; // drop in the cycle after ack
		end else if (fetchReq && !cycleOpen) begin
			cycleOpen <= 1'b1;
		end
	end

	// address frozen for the whole cycle
	always_ff @(posedge clk) begin
		if (fetchReq && !cycleOpen)
			wbAdr <= pc;
	end

	// IR picks up the read data on ack
	always_ff @(posedge clk) begin
		if (reset)
			instr <= '0;
		else if (fetchDone)
			instr <= wbDatIn;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (pcLoad)
			pc <= newPc; // pc + 1 coming back through Z low
	end

endmodule

// File: hw/ldiCore.sv
`timescale 1ns/1ps

module ldiCore import ldiPkg::*; (
	input logic clk,
	input logic reset,
	input logic run,
	output logic wbCyc,
	output logic wbStb,
	output word_t wbAdr,
	input word_t wbDatIn,
	input logic wbAck,
	output logic regWrEn,
	output regIdx_t regWrAddr,
	output word_t regWrData,
	output logic halted
);

	logic fetchReq;
	logic fetchDone;
	logic pcLoad;
	logic yLoad;
	logic zLoad;
	logic zIncMode;
	logic regWrite;
	busSrc_t busSrc;
	word_t instr;  // IR contents
	word_t pc;
	word_t bus;    // internal bus
	word_t baseOut;

	fetchUnit i_fetchUnit (
		.clk(clk),
		.reset(reset),
		.fetchReq(fetchReq),
		.pcLoad(pcLoad),
		.newPc(bus),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.fetchDone(fetchDone),
		.instr(instr),
		.pc(pc)
	);

	controlSequencer i_controlSequencer (
		.clk(clk),
		.reset(reset),
		.run(run),
		.instr(instr),
		.fetchDone(fetchDone),
		.fetchReq(fetchReq),
		.pcLoad(pcLoad),
		.yLoad(yLoad),
		.zLoad(zLoad),
		.zIncMode(zIncMode),
		.regWrite(regWrite),
		.halted(halted),
		.busSrc(busSrc)
	);

	registerFile i_registerFile (
		.clk(clk),
		.reset(reset),
		.regWrite(regWrite),
		.instr(instr),
		.wrData(bus), // Z low in T5
		.baseOut(baseOut)
	);

	busDatapath i_busDatapath (
		.clk(clk),
		.reset(reset),
		.yLoad(yLoad),
		.zLoad(zLoad),
		.zIncMode(zIncMode),
		.busSrc(busSrc),
		.pc(pc),
		.baseOut(baseOut),
		.instr(instr),
		.bus(bus)
	);

	// write port seen from outside
	assign regWrEn = regWrite;
	assign regWrAddr = instr[26:23]; // Ra
	assign regWrData = bus;

endmodule

// File: hw/ldiPkg.sv
`include "ldi_config.svh"

package ldiPkg;

	typedef logic [`DATA_WIDTH-1:0] word_t; // bus and register word
	typedef logic [4:0] opcode_t;            // instr[31:27]
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t; // Ra / Rb select

	// control steps of one instruction
	typedef enum logic [2:0] {
		IDLE,   // waiting for run
		T0,     // pc out, Z = pc + 1, fetch on the bus
		T1,     // pc in from Z low
		T2,     // decode
		T3,     // Y = base
		T4,     // Z = Y + C
		T5,     // Ra = Z low
		HALTED  // halt opcode seen
	} seqState_t;

	// who drives the internal bus
	typedef enum logic [2:0] {
		NONE,   // bus idles at zero
		PC,
		ZLOW,
		REGB,   // base read, zero for r0
		CONST   // sign extended C
	} busSrc_t;

endpackage

// File: hw/registerFile.sv
`timescale 1ns/1ps
`include "ldi_config.svh"

module registerFile import ldiPkg::*; (
	input logic clk,
	input logic reset,
	input logic regWrite,
	input word_t instr,   // Ra / Rb taken straight from the IR
	input word_t wrData,
	output word_t baseOut // base for ldi
);

	word_t regs [`REG_COUNT];
	regIdx_t ra;
	regIdx_t rb;

	assign ra = instr[26:23]; // Gra
	assign rb = instr[22:19]; // Grb

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (regWrite) begin
			regs[ra] <= wrData;
		end
	end

	// BAout: r0 as base reads as zero
	// r0 still holds whatever was written to it
	assign baseOut = (rb == '0) ? '0 : regs[rb];

endmodule

// File: include/ldi_config.svh
`ifndef LDI_CONFIG_SVH
`define LDI_CONFIG_SVH

// word, register and bus width
`define DATA_WIDTH 32

// general registers, index is 4 bits
`define REG_COUNT 16

// immediate field C, sign extended to a word
`define CONST_WIDTH 19

// opcodes in bits 31..27
`define OP_LDI 5'b00001   // ldi Ra, C(Rb)
`define OP_HALT 5'b11011  // stops fetching

// layout: op 31..27, Ra 26..23, Rb 22..19, C 18..0

`endif

// File: run.sh
#!/bin/bash
# build ldiCoreTb with Verilator, run it, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module ldiCoreTb -f compile.f -o ldiCoreSim \
	&& ./obj_dir/ldiCoreSim 2>&1 | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "Finished with errors" sim.log && { echo "FAILED"; exit 1; } || echo "PASSED"

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
	parameter int PERIOD = 10,     // ns
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// sync reset, released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// File: test/ldiCoreTb.sv
`timescale 1ns/1ps
`include "ldi_config.svh"

module ldiCoreTb import ldiPkg::*; ();

	localparam int TABLE_LEN = 16;
	localparam int HALT_IDX = 13;      // words past this must never be fetched
	localparam int MAX_WAIT = 3;
	localparam int WRITE_DELAY = 5;    // ack edge to write edge with T1..T4 in between
	localparam int CYCLES_PER_INSTR = 9 + MAX_WAIT; // worst T0 plus T1..T5
	localparam int QUIET_CYCLES = 12;  // longer than one T0 step
	localparam int TIMEOUT_CYCLES = TABLE_LEN * CYCLES_PER_INSTR + QUIET_CYCLES + 20;

	logic clk, reset;
	logic run = 1'b0;
	logic wbAck = 1'b0;
	word_t wbDatIn = '0;
	logic wbCyc, wbStb, regWrEn, halted;
	word_t wbAdr, regWrData;
	regIdx_t regWrAddr;

	// instruction table indexed by word address
	word_t instrTable [TABLE_LEN];
	logic expWrite [TABLE_LEN];
	regIdx_t expIdx [TABLE_LEN];
	word_t model [`REG_COUNT]; // expected register contents

	integer seed = 32'ha6877e52;
	int errorCount = 0;
	int writesChecked, writesExpected, acksDone, waitLeft, cycleNo, dueCycle, dueIdx;
	logic dueValid, busy, haltFetched;
	word_t nextAdr, reqAdr;

	clockGen i_clockGen (.*);
	ldiCore i_ldiCore (.*);

	function automatic word_t ldiWord(regIdx_t ra, regIdx_t rb, int c);
		return {`OP_LDI, ra, rb, c[`CONST_WIDTH-1:0]};
	endfunction

	function automatic word_t opWord(opcode_t op);
		return {op, 27'h1234567}; // other fields filled so only the opcode decides
	endfunction

	// R[Ra] = base + C with a zero base for r0
	function automatic word_t expectedValue(word_t w);
		regIdx_t rb;
		int cVal;
		rb = w[22:19];
		cVal = $signed(w[`CONST_WIDTH-1:0]); // sign extends into int
		return ((rb == 0) ? word_t'(0) : model[rb]) + word_t'(cVal);
	endfunction

	function automatic word_t readMem(word_t adr);
		return (adr < TABLE_LEN) ? instrTable[int'(adr)] : ~adr; // fill outside the table
	endfunction

	task automatic setEntry(int i, word_t w, logic wr, regIdx_t idx);
		instrTable[i] = w;
		expWrite[i] = wr;
		expIdx[i] = idx;
	endtask

	task automatic reportError(string what);
		errorCount++;
		$display("%0t: %s", $time, what);
	endtask

	task automatic checkData(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkIdx(string name, regIdx_t got, regIdx_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkAddr(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	// Wishbone slave with a random wait before each ack
	always @(posedge clk) begin
		if (reset) begin
			wbAck <= 1'b0;
			busy <= 1'b0;
			waitLeft <= 0;
			nextAdr <= '0; // pc starts at 0
			haltFetched <= 1'b0;
		end else begin
			wbAck <= 1'b0; // single cycle ack
			if (wbStb !== wbCyc)
				reportError("wbStb does not follow wbCyc");
			if (wbCyc && !wbAck) begin
				if (!busy) begin
					if (haltFetched)
						reportError($sformatf("fetch from %h after the halt word", wbAdr));
					checkAddr("wbAdr", wbAdr, nextAdr); // 0, 1, 2 in order
					nextAdr <= nextAdr + 1;
					reqAdr <= nextAdr;
					busy <= 1'b1;
					waitLeft <= $unsigned($random(seed)) % (MAX_WAIT + 1);
				end else begin
					checkAddr("wbAdr", wbAdr, reqAdr); // held until ack
					if (waitLeft == 0) begin
						wbAck <= 1'b1;
						wbDatIn <= readMem(wbAdr);
						busy <= 1'b0;
						if (readMem(wbAdr) == opWord(`OP_HALT))
							haltFetched <= 1'b1;
					end else
						waitLeft <= waitLeft - 1;
				end
			end
		end
	end

	// write port monitor timed from the ack edge
	always @(posedge clk) begin
		if (reset) begin
			cycleNo <= 0;
			acksDone <= 0;
			dueValid <= 1'b0;
			writesChecked <= 0;
			for (int r = 0; r < `REG_COUNT; r++)
				model[r] <= '0;
		end else begin
			cycleNo <= cycleNo + 1;
			if (wbCyc && wbAck) begin
				acksDone <= acksDone + 1;
				dueCycle <= cycleNo + WRITE_DELAY;
				dueIdx <= acksDone; // n-th fetch is table row n
				dueValid <= (acksDone < TABLE_LEN) && expWrite[acksDone];
			end
			if (regWrEn) begin
				if (dueValid && cycleNo == dueCycle) begin
					checkIdx("regWrAddr", regWrAddr, expIdx[dueIdx]);
					checkData("regWrData", regWrData, expectedValue(instrTable[dueIdx]));
					model[expIdx[dueIdx]] <= expectedValue(instrTable[dueIdx]);
					writesChecked <= writesChecked + 1;
				end else
					reportError($sformatf("unexpected register write at cycle %0d", cycleNo));
			end else if (dueValid && cycleNo == dueCycle)
				reportError($sformatf("no register write after the fetch of word %0d", dueIdx));
			if (dueValid && cycleNo == dueCycle)
				dueValid <= 1'b0;
		end
	end

	initial begin
		setEntry(0, ldiWord(1, 0, 5), 1'b1, 1);           // r1 = 5
		setEntry(1, ldiWord(2, 0, -3), 1'b1, 2);          // negative C
		setEntry(2, opWord(5'b00000), 1'b0, 0);           // no-op
		setEntry(3, ldiWord(3, 1, 100), 1'b1, 3);         // base r1
		setEntry(4, ldiWord(2, 2, 7), 1'b1, 2);           // Ra = Rb
		setEntry(5, ldiWord(4, 0, 32'h3ffff), 1'b1, 4);   // largest C
		setEntry(6, ldiWord(5, 0, -262144), 1'b1, 5);     // smallest C
		setEntry(7, ldiWord(6, 0, -3), 1'b1, 6);
		setEntry(8, ldiWord(7, 6, 10), 1'b1, 7);          // wraps past 2^32
		setEntry(9, opWord(5'b10101), 1'b0, 0);           // no-op
		setEntry(10, ldiWord(0, 0, 9), 1'b1, 0);          // r0 gets written
		setEntry(11, ldiWord(9, 0, 1), 1'b1, 9);          // r0 base still zero
		setEntry(12, ldiWord(10, 4, -6), 1'b1, 10);
		setEntry(HALT_IDX, opWord(`OP_HALT), 1'b0, 0);
		setEntry(14, ldiWord(11, 0, 1), 1'b1, 11);        // past the halt
		setEntry(15, ldiWord(12, 0, 2), 1'b1, 12);
		writesExpected = 0;
		for (int i = 0; i <= HALT_IDX; i++)
			if (expWrite[i])
				writesExpected++;
		wait (reset === 1'b0);
		if (wbCyc !== 1'b0 || wbStb !== 1'b0 || regWrEn !== 1'b0 || halted !== 1'b0)
			reportError("outputs not idle after reset");
		@(posedge clk);
		run <= 1'b1;
		// step through the table one fetch at a time
		for (int i = 0; i <= HALT_IDX; i++)
			while (acksDone <= i)
				@(posedge clk);
		while (!halted)
			@(posedge clk);
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			if (!halted)
				reportError("halted dropped after the halt word");
		end
		if (nextAdr != HALT_IDX + 1)
			reportError($sformatf("%0d words fetched, %0d expected", nextAdr, HALT_IDX + 1));
		if (writesChecked != writesExpected)
			reportError($sformatf("%0d writes seen, %0d expected", writesChecked, writesExpected));
		$display("%0d errors, %0d of %0d register writes checked", errorCount, writesChecked,
			writesExpected);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("run timed out with no halt after %0d cycles, %0d errors so far",
			TIMEOUT_CYCLES, errorCount);
		$display("Finished with errors");
		$finish;
	end

endmodule
